// File: common/rename_pkg.sv
package rename_pkg;

	// ====================
	// Sizes
	// ====================

	// Physical register file, split evenly over the rename lanes
	localparam int NPREGS = 256;

	// Rename lanes per clock, one free list bank per lane
	localparam int NLANES = 4;

	// Registers held by one bank
	localparam int BANK_SIZE = NPREGS / NLANES;

	// Architectural registers tracked by the map table
	localparam int NAREGS = 32;

	// Derived index widths
	localparam int PREG_W = $clog2(NPREGS);
	localparam int AREG_W = $clog2(NAREGS);
	localparam int SLOT_W = $clog2(BANK_SIZE);

	// ====================
	// Tag types
	// ====================

	// Physical tag
	// Upper bits pick the bank, lower bits the slot in that bank
	typedef logic [PREG_W-1:0] pregno_t;

	// Architectural register number
	typedef logic [AREG_W-1:0] aregno_t;

	// Slot within one bank
	typedef logic [SLOT_W-1:0] bankslot_t;

endpackage

// File: renamer/free_fifo.sv
module free_fifo #(
	parameter int BANK = 0
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 alloc,
	input  logic                                 free_val,
	input  rename_pkg::pregno_t                  free_tag,
	input  logic [rename_pkg::BANK_SIZE-1:0]     drain_mask,
	output rename_pkg::pregno_t                  out_tag,
	output logic                                 out_val,
	output rename_pkg::pregno_t                  drained_tag,
	output logic                                 drained_val,
	output logic                                 empty
);

	// Bank number as it appears in the top bits of a tag
	localparam int BANK_W = rename_pkg::PREG_W - rename_pkg::SLOT_W;
	localparam logic [BANK_W-1:0] BANK_ID = BANK_W'(BANK);

	// Count has to reach BANK_SIZE, so one bit wider than a slot index
	localparam int CNT_W = $clog2(rename_pkg::BANK_SIZE + 1);

	// ====================
	// Storage
	// ====================

	// Only slot numbers are stored, the bank part is implied
	rename_pkg::bankslot_t slots [rename_pkg::BANK_SIZE];
	rename_pkg::bankslot_t rd_ptr;
	rename_pkg::bankslot_t wr_ptr;
	logic [CNT_W-1:0]      count;

	// Lowest pending flush slot
	rename_pkg::bankslot_t drain_slot;
	logic                  drain_hit;

	// Tag coming back into this bank this cycle
	rename_pkg::bankslot_t ret_slot;
	logic                  ret_val;

	logic push;
	logic pop;

	// ====================
	// Flush drain select
	// ====================

	// Scan from the top so the lowest set bit wins
	always_comb begin
		drain_slot = '0;
		drain_hit  = 1'b0;
		for (int k = rename_pkg::BANK_SIZE - 1; k >= 0; k--) begin
			if (drain_mask[k]) begin
				drain_slot = rename_pkg::bankslot_t'(k);
				drain_hit  = 1'b1;
			end
		end
	end

	// Drain only gets the return path when no explicit free is present
	assign drained_val = drain_hit & ~free_val;
	assign drained_tag = {BANK_ID, drain_slot};

	// ====================
	// Return and allocate
	// ====================

	// Explicit free has priority over the flush drain
	assign ret_val  = free_val | drained_val;
	assign ret_slot = free_val ? free_tag[rename_pkg::SLOT_W-1:0] : drain_slot;

	assign empty = (count == '0);

	// A returning tag goes straight out if this lane allocates
	assign out_tag = ret_val ? {BANK_ID, ret_slot} : {BANK_ID, slots[rd_ptr]};
	assign out_val = alloc & (ret_val | ~empty);

	// Bypass leaves the list untouched
	assign push = ret_val & ~alloc;
	assign pop  = alloc & ~ret_val & ~empty;

	// ====================
	// List update
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			// Preload the bank in ascending order
			// Bank 0 starts at tag 1 since tag 0 is reserved
			for (int j = 0; j < rename_pkg::BANK_SIZE; j++) begin
				if (BANK == 0)
					slots[j] <= rename_pkg::bankslot_t'(j + 1);
				else
					slots[j] <= rename_pkg::bankslot_t'(j);
			end
			rd_ptr <= '0;
			if (BANK == 0) begin
				wr_ptr <= rename_pkg::bankslot_t'(rename_pkg::BANK_SIZE - 1);
				count  <= CNT_W'(rename_pkg::BANK_SIZE - 1);
			end else begin
				// Full list, write pointer has wrapped back to 0
				wr_ptr <= '0;
				count  <= CNT_W'(rename_pkg::BANK_SIZE);
			end
		end else begin
			if (push) begin
				slots[wr_ptr] <= ret_slot;
				wr_ptr        <= wr_ptr + 1'b1;
				count         <= count + 1'b1;
			end
			// Push and pop never happen together
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				count  <= count - 1'b1;
			end
		end
	end

endmodule

// File: renamer/reg_renamer.sv
module reg_renamer (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             en,
	input  logic [rename_pkg::NLANES-1:0]                    alloc,
	input  logic [rename_pkg::NLANES-1:0]                    free_val,
	input  rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     free_tag,
	input  logic [rename_pkg::NPREGS-1:0]                    flush_mask,
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     new_tag,
	output logic [rename_pkg::NLANES-1:0]                    new_val,
	output logic [rename_pkg::NPREGS-1:0]                    avail,
	output logic                                             stall
);

	localparam int NL = rename_pkg::NLANES;
	localparam int BS = rename_pkg::BANK_SIZE;

	// ====================
	// Lane strobes
	// ====================

	// Gated request lines into the free lists
	logic [NL-1:0] alloc_g;
	logic [NL-1:0] free_g;

	// What each free list reports back
	rename_pkg::pregno_t [NL-1:0] drained_tag;
	logic [NL-1:0]                drained_val;
	logic [NL-1:0]                empty;

	// Tag returned to each bank this cycle
	rename_pkg::pregno_t [NL-1:0] ret_tag;
	logic [NL-1:0]                ret_val;

	logic [NL-1:0] push;
	logic [NL-1:0] pop;
	logic [NL-1:0] starve;

	// Flush registers still waiting to be drained
	logic [rename_pkg::NPREGS-1:0] pend;
	logic [rename_pkg::NPREGS-1:0] drain_clr;

	assign alloc_g = alloc & {NL{en}};

	// Tag 0 is never returned
	always_comb begin
		for (int i = 0; i < NL; i++)
			free_g[i] = free_val[i] & en & (free_tag[i] != '0);
	end

	// ====================
	// Free lists
	// ====================

	for (genvar g = 0; g < NL; g++) begin : g_bank
		free_fifo #(
			.BANK(g)
		) i_free_fifo (
			.clk         (clk),
			.rst         (rst),
			.alloc       (alloc_g[g]),
			.free_val    (free_g[g]),
			.free_tag    (free_tag[g]),
			// Pending bits of this bank whose register is not free yet
			.drain_mask  (pend[g*BS +: BS] & ~avail[g*BS +: BS] & {BS{en}}),
			.out_tag     (new_tag[g]),
			.out_val     (new_val[g]),
			.drained_tag (drained_tag[g]),
			.drained_val (drained_val[g]),
			.empty       (empty[g])
		);

		assign ret_val[g] = free_g[g] | drained_val[g];
		assign ret_tag[g] = free_g[g] ? free_tag[g] : drained_tag[g];

		// Allocated from the list itself, not bypassed
		assign pop[g]  = new_val[g] & ~ret_val[g];
		assign push[g] = ret_val[g] & ~alloc_g[g];

		// Wants a tag but the bank has none and nothing is coming back
		assign starve[g] = alloc_g[g] & empty[g] & ~ret_val[g];
	end

	assign stall = |starve;

	// ====================
	// Availability
	// ====================

	// Lanes touch disjoint banks, so the updates never collide
	always_ff @(posedge clk) begin
		if (rst) begin
			avail    <= '1;
			avail[0] <= 1'b0;
		end else begin
			for (int i = 0; i < NL; i++) begin
				if (pop[i])
					avail[new_tag[i]] <= 1'b0;
				else if (push[i])
					avail[ret_tag[i]] <= 1'b1;
			end
		end
	end

	// ====================
	// Pending flush mask
	// ====================

	// One drained register per bank leaves the mask each cycle
	always_comb begin
		drain_clr = '0;
		for (int i = 0; i < NL; i++) begin
			if (drained_val[i])
				drain_clr[drained_tag[i]] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '0;
		end else if (en) begin
			// Registers already free are dropped from the mask
			pend    <= (pend | flush_mask) & ~avail & ~drain_clr;
			pend[0] <= 1'b0;
		end
	end

endmodule

// File: verilog/rename_map.sv
module rename_map (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             en,
	input  logic [rename_pkg::NLANES-1:0]                    wr_val,
	input  rename_pkg::aregno_t [rename_pkg::NLANES-1:0]     arch_dst,
	input  rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     wr_tag,
	input  rename_pkg::aregno_t [rename_pkg::NLANES-1:0]     src_arch,
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     old_tag,
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     src_tag
);

	localparam int NL = rename_pkg::NLANES;

	// Current physical register per architectural register
	rename_pkg::pregno_t map_q [rename_pkg::NAREGS];

	// Lanes that really write this cycle
	logic [NL-1:0] wr_en;

	assign wr_en = wr_val & {NL{en}};

	// ====================
	// Read ports
	// ====================

	// Sources see the table as it was before this group
	always_comb begin
		for (int i = 0; i < NL; i++)
			src_tag[i] = map_q[src_arch[i]];
	end

	// Old mapping for each destination
	// An earlier lane writing the same register displaces the table value,
	// the latest such lane is the one that counts
	always_comb begin
		for (int i = 0; i < NL; i++) begin
			old_tag[i] = map_q[arch_dst[i]];
			for (int j = 0; j < i; j++) begin
				if (wr_en[j] && arch_dst[j] == arch_dst[i])
					old_tag[i] = wr_tag[j];
			end
		end
	end

	// ====================
	// Write ports
	// ====================

	// Ascending loop order lets the higher lane win on a shared register
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < rename_pkg::NAREGS; a++)
				map_q[a] <= '0;
		end else begin
			for (int i = 0; i < NL; i++) begin
				if (wr_en[i])
					map_q[arch_dst[i]] <= wr_tag[i];
			end
		end
	end

endmodule

// File: verilog/rename_top.sv
module rename_top (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             en,
	// Rename requests
	input  logic [rename_pkg::NLANES-1:0]                    alloc,
	input  rename_pkg::aregno_t [rename_pkg::NLANES-1:0]     arch_dst,
	input  rename_pkg::aregno_t [rename_pkg::NLANES-1:0]     src_arch,
	// Commit frees, one per lane in that lane's bank
	input  logic [rename_pkg::NLANES-1:0]                    free_val,
	input  rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     free_tag,
	// Bulk release on a pipeline flush
	input  logic [rename_pkg::NPREGS-1:0]                    flush_mask,
	// Allocation results
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     new_tag,
	output logic [rename_pkg::NLANES-1:0]                    new_val,
	// Mappings toward the reorder buffer and issue
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     old_tag,
	output rename_pkg::pregno_t [rename_pkg::NLANES-1:0]     src_tag,
	output logic [rename_pkg::NPREGS-1:0]                    avail,
	output logic                                             stall
);

	// ====================
	// Allocator
	// ====================

	reg_renamer i_reg_renamer (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.alloc      (alloc),
		.free_val   (free_val),
		.free_tag   (free_tag),
		.flush_mask (flush_mask),
		.new_tag    (new_tag),
		.new_val    (new_val),
		.avail      (avail),
		.stall      (stall)
	);

	// ====================
	// Map table
	// ====================

	// Only lanes that got a tag update the mapping
	rename_map i_rename_map (
		.clk      (clk),
		.rst      (rst),
		.en       (en),
		.wr_val   (new_val),
		.arch_dst (arch_dst),
		.wr_tag   (new_tag),
		.src_arch (src_arch),
		.old_tag  (old_tag),
		.src_tag  (src_tag)
	);

endmodule

// File: verif/tb_rename_top.sv
module tb_rename_top;

	localparam int PERIOD = 20;
	localparam int NL = rename_pkg::NLANES;
	localparam int BS = rename_pkg::BANK_SIZE;
	localparam int RAND_CYCLES = 400;
	localparam int POST_CYCLES = 200;
	// Reset, warm-up, exhaustion, FIFO order, flush drain and both random phases
	localparam int TOTAL_CYCLES = 3 + 8 + 70 + 10 + 70 + RAND_CYCLES + POST_CYCLES;

	logic                          clk = 1'b0;
	logic                          rst;
	logic                          en;
	logic [NL-1:0]                 alloc;
	rename_pkg::aregno_t [NL-1:0]  arch_dst;
	rename_pkg::aregno_t [NL-1:0]  src_arch;
	logic [NL-1:0]                 free_val;
	rename_pkg::pregno_t [NL-1:0]  free_tag;
	logic [rename_pkg::NPREGS-1:0] flush_mask;
	rename_pkg::pregno_t [NL-1:0]  new_tag;
	logic [NL-1:0]                 new_val;
	rename_pkg::pregno_t [NL-1:0]  old_tag;
	rename_pkg::pregno_t [NL-1:0]  src_tag;
	logic [rename_pkg::NPREGS-1:0] avail;
	logic                          stall;

	// ====================
	// Reference model
	// ====================

	// Per-bank free lists in hand-out order, and the tags each lane holds
	rename_pkg::pregno_t           fl [NL][$];
	rename_pkg::pregno_t           live [NL][$];
	rename_pkg::pregno_t           mmap [rename_pkg::NAREGS];
	logic [rename_pkg::NPREGS-1:0] mavail;
	// Allocated registers released by a flush, still draining
	logic [rename_pkg::NPREGS-1:0] flushed;
	logic                          drain_busy;
	int                            drain_cnt;

	rename_top i_rename_top (.*);

	always #(PERIOD / 2) clk = ~clk;

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "check failed");
	endtask

	task automatic drop_live(input int lane, input rename_pkg::pregno_t t);
		int k;
		k = 0;
		while (k < live[lane].size() && live[lane][k] != t)
			k++;
		if (k < live[lane].size())
			live[lane].delete(k);
	endtask

	// One clock of requests with frees drawn from the tags the lane holds
	task automatic drive_cycle(input logic en_v, input logic [NL-1:0] a,
			input logic [NL-1:0] f, input int dst_max);
		int idx;
		@(posedge clk);
		en <= en_v;
		alloc <= a;
		flush_mask <= '0;
		for (int i = 0; i < NL; i++) begin
			arch_dst[i] <= rename_pkg::aregno_t'($urandom_range(dst_max));
			src_arch[i] <= rename_pkg::aregno_t'($urandom_range(rename_pkg::NAREGS - 1));
			if (en_v && f[i] && live[i].size() != 0) begin
				idx = $urandom_range(live[i].size() - 1);
				free_val[i] <= 1'b1;
				free_tag[i] <= live[i][idx];
			end else begin
				free_val[i] <= 1'b0;
			end
		end
	endtask

	// Flush half of each lane's tags plus one free tag and tag 0
	task automatic flush_cycle();
		logic [rename_pkg::NPREGS-1:0] fmask;
		fmask = '0;
		fmask[0] = 1'b1;
		for (int b = 0; b < NL; b++) begin
			for (int k = 0; k < live[b].size() / 2; k++)
				fmask[live[b][k]] = 1'b1;
			if (fl[b].size() != 0)
				fmask[fl[b][fl[b].size() - 1]] = 1'b1;
		end
		@(posedge clk);
		en <= 1'b1;
		alloc <= '0;
		free_val <= '0;
		flush_mask <= fmask;
		@(posedge clk);
		flush_mask <= '0;
		while (drain_busy)
			@(posedge clk);
	endtask

	// ====================
	// Checking
	// ====================

	assert property (@(posedge clk) disable iff (rst) stall |-> (en && alloc != '0))
		else report_error("stall raised without an enabled allocation");
	assert property (@(posedge clk) disable iff (rst) (new_val & ~(alloc & {NL{en}})) == '0)
		else report_error("new_val set on a lane without an enabled allocation");

	// Outputs settle after the rising edge, so compare on the falling edge
	always @(negedge clk) begin : model_check
		logic [NL-1:0]                exp_val;
		rename_pkg::pregno_t [NL-1:0] exp_tag;
		rename_pkg::pregno_t          exp_old;
		logic                         exp_stall;
		logic                         act;
		logic                         fre;
		if (rst) begin
			// Banks start full and ascending, tag 0 held back
			for (int b = 0; b < NL; b++) begin
				fl[b].delete();
				live[b].delete();
				for (int s = 0; s < BS; s++)
					if (b * BS + s != 0)
						fl[b].push_back(rename_pkg::pregno_t'(b * BS + s));
			end
			for (int a = 0; a < rename_pkg::NAREGS; a++)
				mmap[a] = '0;
			mavail = '1;
			mavail[0] = 1'b0;
			flushed = '0;
			drain_busy = 1'b0;
			drain_cnt = 0;
		end else if (drain_busy) begin
			drain_cnt++;
			if (avail === (mavail | flushed)) begin
				// Drained tags join each list lowest first
				for (int p = 1; p < rename_pkg::NPREGS; p++)
					if (flushed[p])
						fl[p / BS].push_back(rename_pkg::pregno_t'(p));
				mavail = mavail | flushed;
				flushed = '0;
				drain_busy = 1'b0;
			end else begin
				assert (drain_cnt < 64)
					else report_error("flush drain not finished within 64 cycles");
			end
		end else begin
			assert (avail === mavail)
				else report_error($sformatf("avail differs from model, bits %h", avail ^ mavail));
			exp_stall = 1'b0;
			for (int i = 0; i < NL; i++) begin
				act = en & alloc[i];
				fre = en & free_val[i] & (free_tag[i] != '0);
				exp_val[i] = 1'b0;
				exp_tag[i] = '0;
				if (fre)
					drop_live(i, free_tag[i]);
				if (act && fre) begin
					// Bypass, list and avail stay as they are
					exp_val[i] = 1'b1;
					exp_tag[i] = free_tag[i];
				end else if (act && fl[i].size() != 0) begin
					exp_val[i] = 1'b1;
					exp_tag[i] = fl[i].pop_front();
					mavail[exp_tag[i]] = 1'b0;
					// A tag taken from the list must not be held by anyone
					assert (!new_val[i] || avail[new_tag[i]])
						else report_error($sformatf("tag %0d handed out while still allocated",
							new_tag[i]));
				end else if (act) begin
					exp_stall = 1'b1;
				end else if (fre) begin
					fl[i].push_back(free_tag[i]);
					mavail[free_tag[i]] = 1'b1;
				end
			end
			assert (stall === exp_stall)
				else report_error($sformatf("stall %b, expected %b", stall, exp_stall));
			assert (new_val === exp_val)
				else report_error($sformatf("new_val %b, expected %b", new_val, exp_val));
			for (int i = 0; i < NL; i++) begin
				if (exp_val[i]) begin
					assert (new_tag[i] === exp_tag[i])
						else report_error($sformatf("lane %0d new_tag %0d, expected %0d",
							i, new_tag[i], exp_tag[i]));
				end
				// Earlier lanes of the same group displace the table value
				exp_old = mmap[arch_dst[i]];
				for (int j = 0; j < i; j++)
					if (exp_val[j] && arch_dst[j] == arch_dst[i])
						exp_old = exp_tag[j];
				assert (old_tag[i] === exp_old)
					else report_error($sformatf("lane %0d old_tag %0d, expected %0d",
						i, old_tag[i], exp_old));
				assert (src_tag[i] === mmap[src_arch[i]])
					else report_error($sformatf("lane %0d src_tag %0d, expected %0d",
						i, src_tag[i], mmap[src_arch[i]]));
			end
			// Higher lane written last wins
			for (int i = 0; i < NL; i++) begin
				if (exp_val[i]) begin
					mmap[arch_dst[i]] = exp_tag[i];
					live[i].push_back(exp_tag[i]);
				end
			end
			if (en && flush_mask != '0) begin
				for (int p = 1; p < rename_pkg::NPREGS; p++) begin
					if (flush_mask[p] && !mavail[p]) begin
						flushed[p] = 1'b1;
						drop_live(p / BS, rename_pkg::pregno_t'(p));
					end
				end
				drain_busy = |flushed;
				drain_cnt = 0;
			end
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		void'($urandom(32'h410ccdb4));
		rst = 1'b1;
		en = 1'b0;
		alloc = '0;
		arch_dst = '0;
		src_arch = '0;
		free_val = '0;
		free_tag = '0;
		flush_mask = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// Warm-up, every lane walks its bank in ascending order
		repeat (8) drive_cycle(1'b1, 4'hf, 4'h0, 31);
		// Run lane 0 dry, then a starved request and a bypassed one
		while (fl[0].size() != 0)
			drive_cycle(1'b1, 4'h1, 4'h0, 31);
		drive_cycle(1'b1, 4'h1, 4'h0, 31);
		drive_cycle(1'b1, 4'h1, 4'h1, 31);
		// Refill the empty list so tags come back in free order
		repeat (3) drive_cycle(1'b1, 4'h0, 4'h1, 31);
		repeat (4) drive_cycle(1'b1, 4'h1, 4'h0, 31);
		// Few destinations so lanes of a group often collide
		repeat (RAND_CYCLES)
			drive_cycle(($urandom_range(7) != 0), 4'($urandom()), 4'($urandom()), 7);
		flush_cycle();
		repeat (POST_CYCLES) drive_cycle(1'b1, 4'($urandom()), 4'($urandom()), 31);
		@(posedge clk);
		alloc <= '0;
		free_val <= '0;
		// Let the last falling-edge check finish first
		@(negedge clk);
		#(PERIOD / 4);
		$display("*** PASSED ***");
		$finish;
	end

	initial begin
		#(PERIOD * (TOTAL_CYCLES + 200));
		$display("Timeout: the run did not reach its end in the expected time");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: rename_top.f
common/rename_pkg.sv
renamer/free_fifo.sv
renamer/reg_renamer.sv
verilog/rename_map.sv
verilog/rename_top.sv
verif/tb_rename_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the rename front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_rename_top
BUILD_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
if ! verilator --binary --timing --assert --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -f rename_top.f; then
	echo "Build failed"
	exit 1
fi

echo "Running $TOP"
"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the verdict
if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	echo "Simulation reported a failure (exit status $run_status)"
	exit 1
fi
if [ "$run_status" -ne 0 ] || ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
	echo "Simulation ended without a pass (exit status $run_status)"
	exit 1
fi
echo "Simulation passed"
exit 0
